/* source/trace_cfg.svh */
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

`define TRACE_W     4
`define HIST_W      32   // eight nibbles of history
`define NUM_RULES   4
`define RULE_IDX_W  2
`define TS_W        12
`define BUF_DEPTH   64
`define BUF_ADDR_W  6
`define ENTRY_W     16
`define DLY_W       16
`define WID_W       16
`define WB_ADR_W    8
`define WB_DAT_W    32

// word addresses on the host bus
`define REG_CTRL          8'h00
`define REG_STATUS        8'h01
`define REG_TRIG_DELAY    8'h02
`define REG_TRIG_WIDTH    8'h03
`define REG_PATTERN_BASE  8'h10   // rule r: pattern at +2r, mask at +2r+1
`define REG_BUF_BASE      8'h40

// CTRL and STATUS field positions
`define CTRL_RULE_EN_LSB  8
`define CTRL_TRIG_EN_LSB  16
`define STATUS_COUNT_LSB  8

`endif

/* source/trace_pkg.sv */
`include "trace_cfg.svh"

package trace_pkg;

  // record kind, sits in the top two bits of every entry
  typedef enum logic [1:0] {
    TAG_EMPTY = 2'd0,
    TAG_MATCH = 2'd1,
    TAG_WRAP  = 2'd2
  } entry_tag_t;

  typedef struct packed {
    entry_tag_t              tag;
    logic [`RULE_IDX_W-1:0]  rule;
    logic [`TS_W-1:0]        ts;   // short timestamp at the match
  } match_rec_t;

  typedef struct packed {
    entry_tag_t              tag;
    logic [`ENTRY_W-3:0]     wraps;  // timestamp wraps since arm
  } wrap_rec_t;

  // one buffer word, the tag tells which view applies
  typedef union packed {
    match_rec_t  match;
    wrap_rec_t   wrap;
  } capture_entry_t;

  // one HIST_W word per rule
  typedef logic [`NUM_RULES-1:0][`HIST_W-1:0] rule_vec_t;

endpackage

/* source/buf_bus_if.sv */
`include "trace_cfg.svh"

// wishbone classic style access port onto the capture buffer
interface buf_bus_if;

  logic                       cyc;
  logic                       we;
  logic [`BUF_ADDR_W-1:0]     adr;
  trace_pkg::capture_entry_t  dat_w;
  trace_pkg::capture_entry_t  dat_r;
  logic                       ack;   // one cycle, ends the access

  modport initiator (
    output cyc, we, adr, dat_w,
    input  dat_r, ack
  );

  modport target (
    input  cyc, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

/* source/pattern_matcher.sv */
`include "trace_cfg.svh"

module pattern_matcher (
  input  logic                   trace_clk,
  input  logic                   reset,
  input  logic [`TRACE_W-1:0]    trace_data,
  input  logic [`NUM_RULES-1:0]  rule_enable,
  input  trace_pkg::rule_vec_t   patterns,
  input  trace_pkg::rule_vec_t   masks,
  output logic [`NUM_RULES-1:0]  match
);

  logic [`HIST_W-1:0]     history;   // newest nibble in the low bits
  logic [`NUM_RULES-1:0]  hit;

  // masked compare against the history as it stands this cycle
  always_comb begin
    for (int r = 0; r < `NUM_RULES; r++) begin
      hit[r] = rule_enable[r] &&
               ((history & masks[r]) == (patterns[r] & masks[r]));
    end
  end

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      history <= '0;
      match   <= '0;
    end else begin
      history <= {history[`HIST_W-`TRACE_W-1:0], trace_data};
      match   <= hit;   // one edge after the nibble lands
    end
  end

endmodule

/* source/trigger_gen.sv */
`include "trace_cfg.svh"

module trigger_gen (
  input  logic                   trace_clk,
  input  logic                   reset,
  input  logic                   arm_pulse,
  input  logic [`NUM_RULES-1:0]  match,
  input  logic [`NUM_RULES-1:0]  trig_enable,
  input  logic [`DLY_W-1:0]      trig_delay,
  input  logic [`WID_W-1:0]      trig_width,
  output logic                   trig_out
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_DELAY = 2'd1;
  localparam logic [1:0] ST_PULSE = 2'd2;

  logic [1:0]         state;
  logic [`DLY_W-1:0]  cnt;       // shared by delay and width
  logic               fired;     // one shot per arm
  logic               hit;
  logic               fire_now;

  assign hit      = !fired && |(match & trig_enable);
  assign fire_now = (state == ST_IDLE && hit && trig_delay == '0) ||
                    (state == ST_DELAY && cnt == '0);

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      cnt      <= '0;
      fired    <= 1'b1;   // nothing fires before the first arm
      trig_out <= 1'b0;
    end else begin
      if (fire_now) begin
        if (trig_width == '0) begin
          state <= ST_IDLE;   // zero width, no pulse
        end else begin
          trig_out <= 1'b1;
          cnt      <= (`DLY_W)'(trig_width - 1'b1);
          state    <= ST_PULSE;
        end
      end else begin
        case (state)
          ST_IDLE: if (hit) begin
            cnt   <= trig_delay - 1'b1;
            state <= ST_DELAY;
          end
          ST_DELAY: cnt <= cnt - 1'b1;
          ST_PULSE: if (cnt == '0) begin
            trig_out <= 1'b0;
            state    <= ST_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
          default: state <= ST_IDLE;
        endcase
      end
      if (state == ST_IDLE && hit) fired <= 1'b1;
      if (arm_pulse) fired <= 1'b0;
    end
  end

endmodule

/* source/capture_writer.sv */
`include "trace_cfg.svh"

module capture_writer (
  input  logic                   trace_clk,
  input  logic                   reset,
  input  logic                   arm_pulse,
  input  logic [`NUM_RULES-1:0]  match,
  output logic                   capturing,
  output logic                   overflow,
  output logic [`BUF_ADDR_W:0]   entry_count,
  buf_bus_if.initiator           wr_bus
);

  logic [`TS_W-1:0]           ts;
  logic [`ENTRY_W-3:0]        wraps;
  logic                       ts_max;
  logic [`RULE_IDX_W-1:0]     hit_rule;
  trace_pkg::capture_entry_t  new_entry;
  logic                       new_valid;
  trace_pkg::capture_entry_t  pend_entry;
  logic                       pend_valid;
  logic [`BUF_ADDR_W+1:0]     in_use;   // written + pending + in flight
  logic                       room;
  logic                       launch;
  logic                       accept;
  logic                       bus_cyc;
  logic [`BUF_ADDR_W-1:0]     bus_adr;
  trace_pkg::capture_entry_t  bus_dat;

  assign ts_max = &ts;
  assign in_use = {1'b0, entry_count} + (`BUF_ADDR_W+2)'(pend_valid) +
                  (`BUF_ADDR_W+2)'(bus_cyc);
  assign room   = in_use < (`BUF_ADDR_W+2)'(`BUF_DEPTH);
  assign launch = pend_valid && !bus_cyc;
  assign accept = new_valid && room && (!pend_valid || launch);

  assign wr_bus.cyc   = bus_cyc;
  assign wr_bus.we    = 1'b1;
  assign wr_bus.adr   = bus_adr;
  assign wr_bus.dat_w = bus_dat;

  // lowest matching rule wins
  always_comb begin
    hit_rule = '0;
    for (int r = `NUM_RULES - 1; r >= 0; r--) begin
      if (match[r]) hit_rule = r[`RULE_IDX_W-1:0];
    end
  end

  always_comb begin
    new_entry = '0;
    new_valid = 1'b0;
    if (capturing && |match) begin
      new_entry.match.tag  = trace_pkg::TAG_MATCH;
      new_entry.match.rule = hit_rule;
      new_entry.match.ts   = ts;
      new_valid            = 1'b1;
    end else if (capturing && ts_max) begin
      new_entry.wrap.tag   = trace_pkg::TAG_WRAP;
      new_entry.wrap.wraps = wraps + 1'b1;
      new_valid            = 1'b1;
    end
  end

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      ts          <= '0;
      wraps       <= '0;
      entry_count <= '0;
      overflow    <= 1'b0;
      capturing   <= 1'b0;
      pend_valid  <= 1'b0;
      bus_cyc     <= 1'b0;
    end else begin
      if (bus_cyc && wr_bus.ack) bus_cyc <= 1'b0;
      else if (launch) bus_cyc <= 1'b1;
      if (accept) pend_valid <= 1'b1;
      else if (launch) pend_valid <= 1'b0;
      if (arm_pulse) begin
        ts          <= '0;
        wraps       <= '0;
        entry_count <= '0;
        overflow    <= 1'b0;
        capturing   <= 1'b1;
        pend_valid  <= 1'b0;   // leftover from the last run
      end else begin
        if (new_valid && room && !accept) overflow <= 1'b1;
        if (bus_cyc && wr_bus.ack) begin
          entry_count <= entry_count + 1'b1;
          if (entry_count == (`BUF_ADDR_W+1)'(`BUF_DEPTH - 1)) capturing <= 1'b0;
        end
        if (capturing) begin
          if (ts_max && !(|match)) begin
            ts    <= '0;
            wraps <= wraps + 1'b1;
          end else if (!ts_max) begin
            ts <= ts + 1'b1;   // holds at max when a match lands there
          end
        end
      end
    end
  end

  always_ff @(posedge trace_clk) begin
    if (accept) pend_entry <= new_entry;
    if (launch) begin
      bus_adr <= entry_count[`BUF_ADDR_W-1:0];   // nothing else in flight here
      bus_dat <= pend_entry;
    end
  end

endmodule

/* source/capture_buffer.sv */
`include "trace_cfg.svh"

module capture_buffer (
  input  logic        trace_clk,
  input  logic        reset,
  buf_bus_if.target   wr_bus,
  buf_bus_if.target   rd_bus
);

  trace_pkg::capture_entry_t  mem [`BUF_DEPTH];
  trace_pkg::capture_entry_t  rd_data;
  logic [1:0]                 grant;   // bit 0 writer, bit 1 host
  logic                       hold;    // ack cycle, initiator still drops cyc
  logic                       wr_ack;
  logic                       rd_ack;
  logic                       sel_we;
  logic [`BUF_ADDR_W-1:0]     sel_adr;
  trace_pkg::capture_entry_t  sel_dat;

  assign sel_we  = grant[1] ? rd_bus.we    : wr_bus.we;
  assign sel_adr = grant[1] ? rd_bus.adr   : wr_bus.adr;
  assign sel_dat = grant[1] ? rd_bus.dat_w : wr_bus.dat_w;

  assign wr_bus.ack   = wr_ack;
  assign rd_bus.ack   = rd_ack;
  assign wr_bus.dat_r = rd_data;
  assign rd_bus.dat_r = rd_data;

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      grant  <= 2'b00;
      hold   <= 1'b0;
      wr_ack <= 1'b0;
      rd_ack <= 1'b0;
    end else begin
      wr_ack <= 1'b0;
      rd_ack <= 1'b0;
      if (hold) begin
        hold <= 1'b0;
      end else if (|grant) begin
        wr_ack <= grant[0];
        rd_ack <= grant[1];
        grant  <= 2'b00;
        hold   <= 1'b1;
      end else if (wr_bus.cyc) begin
        grant <= 2'b01;   // writer first
      end else if (rd_bus.cyc) begin
        grant <= 2'b10;
      end
    end
  end

  always_ff @(posedge trace_clk) begin
    if (|grant) begin
      if (sel_we) mem[sel_adr] <= sel_dat;
      rd_data <= mem[sel_adr];
    end
  end

endmodule

/* source/trace_regs.sv */
`include "trace_cfg.svh"

module trace_regs (
  input  logic                          trace_clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [`WB_ADR_W-1:0]          wb_adr,
  input  logic [`WB_DAT_W-1:0]          wb_dat_w,
  output logic [`WB_DAT_W-1:0]          wb_dat_r,
  output logic                          wb_ack,
  output logic [`NUM_RULES-1:0]         rule_enable,
  output logic [`NUM_RULES-1:0]         trig_enable,
  output trace_pkg::rule_vec_t          patterns,
  output trace_pkg::rule_vec_t          masks,
  output logic [`DLY_W-1:0]             trig_delay,
  output logic [`WID_W-1:0]             trig_width,
  output logic                          arm_pulse,
  input  logic                          capturing,
  input  logic                          overflow,
  input  logic [`BUF_ADDR_W:0]          entry_count,
  buf_bus_if.initiator                  rd_bus
);

  logic                        req;
  logic                        rule_sel;
  logic                        buf_sel;
  logic                        buf_rd;
  logic [`WB_ADR_W-1:0]        rule_off;
  logic [`WB_ADR_W-1:0]        buf_off;
  logic [`RULE_IDX_W-1:0]      rule_idx;
  logic [`WB_DAT_W-1:0]        rd_mux;
  logic                        rd_cyc;
  logic [`BUF_ADDR_W-1:0]      rd_adr;

  assign req      = wb_cyc && wb_stb && !wb_ack;   // new access, not the ack cycle
  assign rule_off = wb_adr - `REG_PATTERN_BASE;
  assign buf_off  = wb_adr - `REG_BUF_BASE;
  assign rule_idx = rule_off[`RULE_IDX_W:1];
  assign rule_sel = (wb_adr >= `REG_PATTERN_BASE) &&
                    (wb_adr < (`REG_PATTERN_BASE + 2 * `NUM_RULES));
  assign buf_sel  = (wb_adr >= `REG_BUF_BASE) && (wb_adr < (`REG_BUF_BASE + `BUF_DEPTH));
  assign buf_rd   = buf_sel && !wb_we;

  // window is read only
  assign rd_bus.cyc   = rd_cyc;
  assign rd_bus.we    = 1'b0;
  assign rd_bus.adr   = rd_adr;
  assign rd_bus.dat_w = '0;

  always_comb begin
    rd_mux = '0;   // unmapped and window writes read as zero
    if (rule_sel) begin
      rd_mux = rule_off[0] ? masks[rule_idx] : patterns[rule_idx];
    end else begin
      case (wb_adr)
        `REG_CTRL: begin
          rd_mux[`CTRL_RULE_EN_LSB +: `NUM_RULES] = rule_enable;
          rd_mux[`CTRL_TRIG_EN_LSB +: `NUM_RULES] = trig_enable;
        end
        `REG_STATUS: begin
          rd_mux[0] = capturing;
          rd_mux[1] = overflow;
          rd_mux[`STATUS_COUNT_LSB +: `BUF_ADDR_W + 1] = entry_count;
        end
        `REG_TRIG_DELAY: rd_mux[`DLY_W-1:0] = trig_delay;
        `REG_TRIG_WIDTH: rd_mux[`WID_W-1:0] = trig_width;
        default: rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      wb_ack      <= 1'b0;
      arm_pulse   <= 1'b0;
      rd_cyc      <= 1'b0;
      rule_enable <= '0;
      trig_enable <= '0;
      trig_delay  <= '0;
      trig_width  <= '0;
      patterns    <= '0;
      masks       <= '0;
    end else begin
      wb_ack    <= 1'b0;
      arm_pulse <= 1'b0;
      if (rd_cyc) begin
        if (rd_bus.ack) begin   // window read done, hand back to host
          rd_cyc <= 1'b0;
          wb_ack <= 1'b1;
        end
      end else if (req) begin
        if (buf_rd) begin
          rd_cyc <= 1'b1;
        end else begin
          wb_ack <= 1'b1;
          if (wb_we && rule_sel) begin
            if (rule_off[0]) masks[rule_idx] <= wb_dat_w;
            else patterns[rule_idx] <= wb_dat_w;
          end else if (wb_we) begin
            case (wb_adr)
              `REG_CTRL: begin
                arm_pulse   <= wb_dat_w[0];
                rule_enable <= wb_dat_w[`CTRL_RULE_EN_LSB +: `NUM_RULES];
                trig_enable <= wb_dat_w[`CTRL_TRIG_EN_LSB +: `NUM_RULES];
              end
              `REG_TRIG_DELAY: trig_delay <= wb_dat_w[`DLY_W-1:0];
              `REG_TRIG_WIDTH: trig_width <= wb_dat_w[`WID_W-1:0];
              default: ;
            endcase
          end
        end
      end
    end
  end

  always_ff @(posedge trace_clk) begin
    if (!rd_cyc && req && buf_rd) rd_adr <= buf_off[`BUF_ADDR_W-1:0];
    if (rd_cyc && rd_bus.ack) begin
      wb_dat_r <= {{(`WB_DAT_W - `ENTRY_W){1'b0}}, rd_bus.dat_r};
    end else if (!rd_cyc && req && !buf_rd) begin
      wb_dat_r <= rd_mux;
    end
  end

endmodule

/* source/trace_top.sv */
`include "trace_cfg.svh"

module trace_top (
  input  logic                  trace_clk,
  input  logic                  reset,
  input  logic [`TRACE_W-1:0]   trace_data,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`WB_ADR_W-1:0]  wb_adr,
  input  logic [`WB_DAT_W-1:0]  wb_dat_w,
  output logic [`WB_DAT_W-1:0]  wb_dat_r,
  output logic                  wb_ack,
  output logic                  trig_out,
  output logic                  capturing
);

  logic [`NUM_RULES-1:0]  rule_enable;
  logic [`NUM_RULES-1:0]  trig_enable;
  trace_pkg::rule_vec_t   patterns;
  trace_pkg::rule_vec_t   masks;
  logic [`DLY_W-1:0]      trig_delay;
  logic [`WID_W-1:0]      trig_width;
  logic                   arm_pulse;
  logic [`NUM_RULES-1:0]  match;
  logic                   overflow;
  logic [`BUF_ADDR_W:0]   entry_count;

  buf_bus_if wr_bus ();   // capture writer to buffer
  buf_bus_if rd_bus ();   // host window to buffer

  trace_regs u_regs (
    .trace_clk   (trace_clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .rule_enable (rule_enable),
    .trig_enable (trig_enable),
    .patterns    (patterns),
    .masks       (masks),
    .trig_delay  (trig_delay),
    .trig_width  (trig_width),
    .arm_pulse   (arm_pulse),
    .capturing   (capturing),
    .overflow    (overflow),
    .entry_count (entry_count),
    .rd_bus      (rd_bus)
  );

  pattern_matcher u_matcher (
    .trace_clk   (trace_clk),
    .reset       (reset),
    .trace_data  (trace_data),
    .rule_enable (rule_enable),
    .patterns    (patterns),
    .masks       (masks),
    .match       (match)
  );

  trigger_gen u_trigger (
    .trace_clk   (trace_clk),
    .reset       (reset),
    .arm_pulse   (arm_pulse),
    .match       (match),
    .trig_enable (trig_enable),
    .trig_delay  (trig_delay),
    .trig_width  (trig_width),
    .trig_out    (trig_out)
  );

  capture_writer u_writer (
    .trace_clk   (trace_clk),
    .reset       (reset),
    .arm_pulse   (arm_pulse),
    .match       (match),
    .capturing   (capturing),
    .overflow    (overflow),
    .entry_count (entry_count),
    .wr_bus      (wr_bus)
  );

  capture_buffer u_buffer (
    .trace_clk   (trace_clk),
    .reset       (reset),
    .wr_bus      (wr_bus),
    .rd_bus      (rd_bus)
  );

endmodule

/* testbench/tb_wb_tasks.svh */
// host bus accesses, all signal changes on the falling edge
task automatic write_reg(input logic [`WB_ADR_W-1:0] addr,
                         input logic [`WB_DAT_W-1:0] data);
  @(negedge trace_clk);
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = 1'b1;
  wb_adr   = addr;
  wb_dat_w = data;
  @(negedge trace_clk);
  while (!wb_ack) @(negedge trace_clk);
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we  = 1'b0;
endtask

task automatic read_reg(input logic [`WB_ADR_W-1:0] addr,
                        output logic [`WB_DAT_W-1:0] data);
  @(negedge trace_clk);
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we  = 1'b0;
  wb_adr = addr;
  @(negedge trace_clk);
  while (!wb_ack) @(negedge trace_clk);   // window reads take longer
  data   = wb_dat_r;
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
endtask

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    $display("mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
             cur_test, what, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  end
endtask

task automatic set_rule(input int r, input logic [31:0] pattern, input logic [31:0] mask);
  write_reg(`REG_PATTERN_BASE + 8'(2 * r), pattern);
  write_reg(`REG_PATTERN_BASE + 8'(2 * r + 1), mask);
endtask

// CTRL write with the arm bit set
task automatic arm_capture(input logic [3:0] rule_en, input logic [3:0] trig_en);
  write_reg(`REG_CTRL, (32'(trig_en) << `CTRL_TRIG_EN_LSB) |
                       (32'(rule_en) << `CTRL_RULE_EN_LSB) | 32'd1);
endtask

task automatic fetch_entry(input int idx, output trace_pkg::capture_entry_t entry);
  logic [`WB_DAT_W-1:0] word;
  read_reg(`REG_BUF_BASE + 8'(idx), word);
  check_value($sformatf("entry %0d upper half", idx), 32'd0, {16'd0, word[31:16]});
  entry = word[`ENTRY_W-1:0];
endtask

// polls STATUS until the writer has logged enough entries
task automatic wait_entries(input int count);
  logic [`WB_DAT_W-1:0] st;
  read_reg(`REG_STATUS, st);
  while (int'(st[`STATUS_COUNT_LSB +: `BUF_ADDR_W + 1]) < count) begin
    read_reg(`REG_STATUS, st);
  end
endtask

/* testbench/tb_trace_top.sv */
`include "trace_cfg.svh"

module tb_trace_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SPACING      = 12;   // cycles between completing nibbles
  localparam int FULL_MATCHES = `BUF_DEPTH + 3;
  localparam int LIVE_MATCHES = 10;
  localparam int WRAP_WAIT    = 4100;
  localparam int TRIG_DELAY   = 5;
  localparam int TRIG_WIDTH   = 3;
  // wrap test about 4100 cycles, the other tests under 4000 together
  localparam int TIMEOUT_CYCLES = 20000;

  localparam logic [31:0] PAT_R0     = 32'h0000_abcd;
  localparam logic [31:0] PAT_R1     = 32'h0000_f1e2;
  localparam logic [31:0] MASK_R1    = 32'h0000_f0f0;   // only F?E? counts
  localparam logic [31:0] PAT_R2     = 32'h0000_9b8c;
  localparam logic [31:0] PAT_R3     = 32'h0000_00dd;
  localparam logic [31:0] MASK_LOW16 = 32'h0000_ffff;

  logic                  trace_clk;
  logic                  reset;
  logic [`TRACE_W-1:0]   trace_data;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`WB_ADR_W-1:0]  wb_adr;
  logic [`WB_DAT_W-1:0]  wb_dat_w;
  logic [`WB_DAT_W-1:0]  wb_dat_r;
  logic                  wb_ack;
  logic                  trig_out;
  logic                  capturing;

  integer seed        = 1411;
  int     cycle_count = 0;
  string  cur_test    = "reset";

  trace_top dut (
    .trace_clk  (trace_clk),
    .reset      (reset),
    .trace_data (trace_data),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .trig_out   (trig_out),
    .capturing  (capturing)
  );

  `include "tb_wb_tasks.svh"

  initial begin
    trace_clk = 1'b0;
    forever #10 trace_clk = ~trace_clk;
  end

  always @(posedge trace_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles in %s", cycle_count, cur_test);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // filler stays below 8, so it never builds a pattern nibble
  function automatic logic [3:0] pick_filler();
    integer rnd;
    rnd = $random(seed);
    return {1'b0, rnd[2:0]};
  endfunction

  function automatic logic [31:0] status_word(input int count, input logic ovf,
                                              input logic cap);
    return (32'(count) << `STATUS_COUNT_LSB) | {30'd0, ovf, cap};
  endfunction

  task automatic random_filler(input int n);
    repeat (n) begin
      @(negedge trace_clk);
      trace_data = pick_filler();
    end
  endtask

  // oldest nibble first, the last one completes the pattern
  task automatic play_pattern(input logic [31:0] word, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      @(negedge trace_clk);
      trace_data = word[i*4 +: 4];
    end
  endtask

  // edges counted from the one that samples the completing nibble
  task automatic measure_pulse(input int window, output int rise_edge,
                               output int high_cycles, output int last_edge);
    rise_edge   = -1;
    high_cycles = 0;
    last_edge   = -1;
    for (int k = 1; k <= window; k++) begin
      @(negedge trace_clk);
      trace_data = pick_filler();
      if (trig_out) begin
        if (rise_edge < 0) rise_edge = k - 1;
        high_cycles++;
        last_edge = k - 1;
      end
    end
  endtask

  task automatic registers_rw();
    logic [31:0] rd;
    logic [31:0] pat;
    cur_test = "registers";
    read_reg(`REG_STATUS, rd);
    check_value("status after reset", 32'd0, rd);
    write_reg(`REG_TRIG_DELAY, 32'h0000_1234);
    write_reg(`REG_TRIG_WIDTH, 32'h0000_0056);
    read_reg(`REG_TRIG_DELAY, rd);
    check_value("trigger delay", 32'h0000_1234, rd);
    read_reg(`REG_TRIG_WIDTH, rd);
    check_value("trigger width", 32'h0000_0056, rd);
    for (int r = 0; r < `NUM_RULES; r++) begin
      pat = 32'h1357_9bdf + 32'(r) * 32'h1111_1111;
      set_rule(r, pat, ~pat);
      read_reg(`REG_PATTERN_BASE + 8'(2 * r), rd);
      check_value($sformatf("pattern %0d", r), pat, rd);
      read_reg(`REG_PATTERN_BASE + 8'(2 * r + 1), rd);
      check_value($sformatf("mask %0d", r), ~pat, rd);
    end
    read_reg(8'h30, rd);   // unmapped
    check_value("unmapped read", 32'd0, rd);
  endtask

  task automatic match_log();
    logic [31:0]               rd;
    trace_pkg::capture_entry_t e [3];
    int                        exp_rule [3];
    exp_rule = '{2, 0, 1};
    cur_test = "match_log";
    set_rule(0, PAT_R0, MASK_LOW16);
    set_rule(1, PAT_R1, MASK_R1);
    set_rule(2, PAT_R2, MASK_LOW16);
    set_rule(3, PAT_R3, 32'h0000_00ff);   // stays disabled
    arm_capture(4'b0111, 4'b0000);
    random_filler(6);
    play_pattern(PAT_R2, 4);
    random_filler(SPACING - 4);
    play_pattern(PAT_R0, 4);
    random_filler(SPACING - 4);
    play_pattern(32'h0000_f3e5, 4);   // hits rule 1 only through its mask
    random_filler(SPACING - 4);
    play_pattern(PAT_R3, 2);
    random_filler(SPACING);
    read_reg(`REG_STATUS, rd);
    check_value("status", status_word(3, 1'b0, 1'b1), rd);
    for (int k = 0; k < 3; k++) begin
      fetch_entry(k, e[k]);
      check_value($sformatf("tag %0d", k), 32'(trace_pkg::TAG_MATCH), 32'(e[k].match.tag));
      check_value($sformatf("rule %0d", k), 32'(exp_rule[k]), 32'(e[k].match.rule));
      if (k > 0) begin
        check_value($sformatf("ts step %0d", k), 32'(SPACING),
                    32'(e[k].match.ts) - 32'(e[k-1].match.ts));
      end
    end
  endtask

  task automatic trigger_pulse();
    int rise;
    int high;
    int last;
    cur_test = "trigger_pulse";
    write_reg(`REG_TRIG_DELAY, 32'(TRIG_DELAY));
    write_reg(`REG_TRIG_WIDTH, 32'(TRIG_WIDTH));
    set_rule(0, PAT_R0, MASK_LOW16);
    arm_capture(4'b0001, 4'b0001);
    random_filler(4);
    check_value("trig_out before match", 32'd0, 32'(trig_out));
    play_pattern(PAT_R0, 4);
    measure_pulse(TRIG_DELAY + TRIG_WIDTH + 8, rise, high, last);
    check_value("first high edge", 32'(2 + TRIG_DELAY), 32'(rise));
    check_value("pulse width", 32'(TRIG_WIDTH), 32'(high));
    check_value("pulse in one piece", 32'(high), 32'(last - rise + 1));
    // no rearm, so a second match is ignored
    random_filler(4);
    play_pattern(PAT_R0, 4);
    measure_pulse(TRIG_DELAY + TRIG_WIDTH + 8, rise, high, last);
    check_value("second match cycles", 32'd0, 32'(high));
    write_reg(`REG_TRIG_WIDTH, 32'd0);
    arm_capture(4'b0001, 4'b0001);
    random_filler(4);
    play_pattern(PAT_R0, 4);
    measure_pulse(TRIG_DELAY + 8, rise, high, last);
    check_value("zero width cycles", 32'd0, 32'(high));
  endtask

  task automatic wrap_record();
    logic [31:0]               rd;
    trace_pkg::capture_entry_t e;
    cur_test = "wrap_record";
    arm_capture(4'b0000, 4'b0000);
    repeat (WRAP_WAIT) @(negedge trace_clk);
    wait_entries(1);
    read_reg(`REG_STATUS, rd);
    check_value("status", status_word(1, 1'b0, 1'b1), rd);
    fetch_entry(0, e);
    check_value("tag", 32'(trace_pkg::TAG_WRAP), 32'(e.wrap.tag));
    check_value("wrap count", 32'd1, 32'(e.wrap.wraps));
  endtask

  task automatic buffer_full();
    logic [31:0]               rd;
    trace_pkg::capture_entry_t first;
    trace_pkg::capture_entry_t prev;
    trace_pkg::capture_entry_t last;
    cur_test = "buffer_full";
    set_rule(0, PAT_R0, MASK_LOW16);
    arm_capture(4'b0001, 4'b0000);
    repeat (FULL_MATCHES) begin
      play_pattern(PAT_R0, 4);
      random_filler(SPACING - 4);
    end
    check_value("capturing pin", 32'd0, 32'(capturing));
    read_reg(`REG_STATUS, rd);
    check_value("status", status_word(`BUF_DEPTH, 1'b0, 1'b0), rd);
    fetch_entry(0, first);
    fetch_entry(`BUF_DEPTH - 2, prev);
    fetch_entry(`BUF_DEPTH - 1, last);
    check_value("last tag", 32'(trace_pkg::TAG_MATCH), 32'(last.match.tag));
    check_value("last rule", 32'd0, 32'(last.match.rule));
    check_value("last ts step", 32'(SPACING), 32'(last.match.ts) - 32'(prev.match.ts));
    // span from the first entry pins down which match was kept last
    check_value("last ts span", 32'((`BUF_DEPTH - 1) * SPACING),
                32'(last.match.ts) - 32'(first.match.ts));
  endtask

  task automatic read_during_capture();
    trace_pkg::capture_entry_t e;
    logic [`TS_W-1:0]          ts0;
    cur_test = "read_during_capture";
    ts0 = '0;
    set_rule(0, PAT_R0, MASK_LOW16);
    set_rule(2, PAT_R2, MASK_LOW16);
    arm_capture(4'b0101, 4'b0000);
    fork
      begin
        for (int f = 0; f < LIVE_MATCHES; f++) begin
          play_pattern((f % 2) ? PAT_R2 : PAT_R0, 4);
          random_filler(SPACING - 4);
        end
      end
      begin
        for (int k = 0; k < LIVE_MATCHES; k++) begin
          wait_entries(k + 1);   // reads overlap the writer's accesses
          fetch_entry(k, e);
          check_value($sformatf("tag %0d", k), 32'(trace_pkg::TAG_MATCH), 32'(e.match.tag));
          check_value($sformatf("rule %0d", k), (k % 2) ? 32'd2 : 32'd0, 32'(e.match.rule));
          if (k == 0) ts0 = e.match.ts;
          else check_value($sformatf("ts %0d", k), 32'(ts0) + 32'(k * SPACING),
                           32'(e.match.ts));
        end
      end
    join
  endtask

  initial begin
    reset      = 1'b1;
    trace_data = '0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    repeat (4) @(negedge trace_clk);
    reset = 1'b0;
    registers_rw();
    match_log();
    trigger_pulse();
    wrap_record();
    buffer_full();
    read_during_capture();
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* all.f */
+incdir+source
+incdir+testbench
source/trace_pkg.sv
source/buf_bus_if.sv
source/pattern_matcher.sv
source/trigger_gen.sv
source/capture_writer.sv
source/capture_buffer.sv
source/trace_regs.sv
source/trace_top.sv
testbench/tb_trace_top.sv

/* run.sh */
#!/usr/bin/env bash
# builds the trace sniffer testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_trace_top -f all.f \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_trace_top > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation gave no result, see sim.log"; exit 1; }
echo "simulation passed"
